// File: Bender.yml
package:
  name: exec_top

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - mem_bus_if.sv
      - alu.sv
      - exec_unit.sv
      - load_store_unit.sv
      - bus_arbiter.sv
      - data_sram.sv
      - exec_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exec_top.sv

// File: alu.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module alu (
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    input  exu_pkg::alu_op_e     op,
    input  exu_pkg::branch_e     branch,
    output logic [`EXU_XLEN-1:0] result,
    output logic                 taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // ----------------------------------------
    // arithmetic and logic
    // ----------------------------------------

    always_comb begin
        case (op)
            exu_pkg::alu_add:    result = a + b;
            exu_pkg::alu_sub:    result = a - b;
            exu_pkg::alu_sll:    result = a << shamt;
            exu_pkg::alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            exu_pkg::alu_sltu:   result = {31'b0, a < b};
            exu_pkg::alu_xor:    result = a ^ b;
            exu_pkg::alu_srl:    result = a >> shamt;
            exu_pkg::alu_sra:    result = $signed(a) >>> shamt;
            exu_pkg::alu_or:     result = a | b;
            exu_pkg::alu_and:    result = a & b;
            exu_pkg::alu_pass_b: result = b;
            default:             result = '0;
        endcase
    end

    // ----------------------------------------
    // branch condition
    // ----------------------------------------

    always_comb begin
        case (branch)
            exu_pkg::br_jal,
            exu_pkg::br_jalr: taken = 1'b1;
            exu_pkg::br_beq:  taken = (a == b);
            exu_pkg::br_bne:  taken = (a != b);
            exu_pkg::br_blt:  taken = $signed(a) < $signed(b);
            exu_pkg::br_bge:  taken = $signed(a) >= $signed(b);
            exu_pkg::br_bltu: taken = a < b;
            default:          taken = 1'b0;
        endcase
    end

endmodule

// File: build.f
+incdir+.
exu_pkg.sv
mem_bus_if.sv
alu.sv
exec_unit.sv
load_store_unit.sv
bus_arbiter.sv
data_sram.sv
exec_top.sv
tb_exec_top.sv

// File: bus_arbiter.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module bus_arbiter (
    input  logic                   clock,
    input  logic                   reset,
    mem_bus_if.slave               lsu,
    mem_bus_if.slave               host,
    output logic                   sram_en,
    output logic [3:0]             sram_we,
    output logic [`EXU_MEM_AW-1:0] sram_addr,
    output logic [`EXU_XLEN-1:0]   sram_wdata,
    input  logic [`EXU_XLEN-1:0]   sram_rdata
);

    logic last_host;
    logic pick_host;
    logic win_write;
    logic rd_busy;
    logic rd_host;

    // ----------------------------------------
    // round robin grant
    // ----------------------------------------

    // host wins when alone, or on a tie when the lsu won last
    assign pick_host = host.req && (!lsu.req || !last_host);
    assign host.gnt  = pick_host;
    assign lsu.gnt   = lsu.req && !pick_host;

    assign sram_en    = lsu.req || host.req;
    assign win_write  = pick_host ? host.write : lsu.write;
    assign sram_addr  = pick_host ? host.addr  : lsu.addr;
    assign sram_wdata = pick_host ? host.wdata : lsu.wdata;
    assign sram_we    = (sram_en && win_write) ? (pick_host ? host.be : lsu.be) : 4'b0000;

    // ----------------------------------------
    // read return routing
    // ----------------------------------------

    assign lsu.rvalid  = rd_busy && !rd_host;
    assign host.rvalid = rd_busy && rd_host;
    assign lsu.rdata   = rd_host ? '0 : sram_rdata;
    assign host.rdata  = rd_host ? sram_rdata : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            last_host <= 1'b0;
            rd_busy   <= 1'b0;
            rd_host   <= 1'b0;
        end else begin
            if (sram_en)
                last_host <= pick_host;
            rd_busy <= sram_en && !win_write;
            rd_host <= pick_host;
        end
    end

endmodule

// File: data_sram.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module data_sram (
    input  logic                   clock,
    input  logic                   en,
    input  logic [3:0]             we,
    input  logic [`EXU_MEM_AW-1:0] addr,
    input  logic [`EXU_XLEN-1:0]   wdata,
    output logic [`EXU_XLEN-1:0]   rdata
);

    logic [`EXU_XLEN-1:0] mem [`EXU_MEM_WORDS];

    // ----------------------------------------
    // byte-lane write, registered read
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i])
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
            rdata <= mem[addr];
        end
    end

endmodule

// File: exec_top.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exec_top (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   issue_valid,
    output logic                   issue_ready,
    input  exu_pkg::exu_op_t       op,
    input  logic [`EXU_REG_W-1:0]  rd,
    input  logic [`EXU_REG_W-1:0]  rs1_idx,
    input  logic [`EXU_REG_W-1:0]  rs2_idx,
    input  logic [`EXU_XLEN-1:0]   pc,
    input  logic [`EXU_XLEN-1:0]   imm,
    input  logic [`EXU_XLEN-1:0]   rs1,
    input  logic [`EXU_XLEN-1:0]   rs2,

    output logic                   wb_valid,
    output logic [`EXU_REG_W-1:0]  wb_rd,
    output logic [`EXU_XLEN-1:0]   wb_data,
    output logic                   redirect_valid,
    output logic [`EXU_XLEN-1:0]   redirect_pc,
    output logic                   store_done,

    input  logic                   host_req,
    input  logic                   host_write,
    input  logic [`EXU_MEM_AW-1:0] host_addr,
    input  logic [`EXU_XLEN-1:0]   host_wdata,
    input  logic [3:0]             host_be,
    output logic                   host_gnt,
    output logic                   host_rvalid,
    output logic [`EXU_XLEN-1:0]   host_rdata
);

    logic                   mem_valid, lsu_ready, load_done, lsu_wb;
    exu_pkg::mem_req_t      mem_req;
    logic                   exu_wb_valid;
    logic [`EXU_REG_W-1:0]  exu_wb_rd, lsu_wb_rd;
    logic [`EXU_XLEN-1:0]   exu_wb_data, lsu_wb_data;
    logic                   sram_en;
    logic [3:0]             sram_we;
    logic [`EXU_MEM_AW-1:0] sram_addr;
    logic [`EXU_XLEN-1:0]   sram_wdata, sram_rdata;

    mem_bus_if lsu_bus ();
    mem_bus_if host_bus ();

    // ----------------------------------------
    // host port mapping
    // ----------------------------------------

    assign host_bus.req   = host_req;
    assign host_bus.write = host_write;
    assign host_bus.addr  = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_bus.be    = host_be;
    assign host_gnt       = host_bus.gnt;
    assign host_rvalid    = host_bus.rvalid;
    assign host_rdata     = host_bus.rdata;

    // load write-back has priority, exec_unit defers its own
    assign wb_valid = lsu_wb || exu_wb_valid;
    assign wb_rd    = lsu_wb ? lsu_wb_rd   : exu_wb_rd;
    assign wb_data  = lsu_wb ? lsu_wb_data : exu_wb_data;

    // ----------------------------------------
    // instances
    // ----------------------------------------

    exec_unit u_exec_unit (
        .clock          (clock),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .op             (op),
        .rd             (rd),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .pc             (pc),
        .imm            (imm),
        .rs1            (rs1),
        .rs2            (rs2),
        .mem_valid      (mem_valid),
        .lsu_ready      (lsu_ready),
        .mem_req        (mem_req),
        .load_done      (load_done),
        .lsu_wb         (lsu_wb),
        .wb_valid       (exu_wb_valid),
        .wb_rd          (exu_wb_rd),
        .wb_data        (exu_wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    load_store_unit u_lsu (
        .clock      (clock),
        .reset      (reset),
        .mem_valid  (mem_valid),
        .lsu_ready  (lsu_ready),
        .mem_req    (mem_req),
        .bus        (lsu_bus.master),
        .load_done  (load_done),
        .lsu_wb     (lsu_wb),
        .wb_rd      (lsu_wb_rd),
        .wb_data    (lsu_wb_data),
        .store_done (store_done)
    );

    bus_arbiter u_arbiter (
        .clock      (clock),
        .reset      (reset),
        .lsu        (lsu_bus.slave),
        .host       (host_bus.slave),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata)
    );

    data_sram u_sram (
        .clock (clock),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exec_unit (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  issue_valid,
    output logic                  issue_ready,
    input  exu_pkg::exu_op_t      op,
    input  logic [`EXU_REG_W-1:0] rd,
    input  logic [`EXU_REG_W-1:0] rs1_idx,
    input  logic [`EXU_REG_W-1:0] rs2_idx,
    input  logic [`EXU_XLEN-1:0]  pc,
    input  logic [`EXU_XLEN-1:0]  imm,
    input  logic [`EXU_XLEN-1:0]  rs1,
    input  logic [`EXU_XLEN-1:0]  rs2,

    output logic                  mem_valid,
    input  logic                  lsu_ready,
    output exu_pkg::mem_req_t     mem_req,
    input  logic                  load_done,
    input  logic                  lsu_wb,

    output logic                  wb_valid,
    output logic [`EXU_REG_W-1:0] wb_rd,
    output logic [`EXU_XLEN-1:0]  wb_data,
    output logic                  redirect_valid,
    output logic [`EXU_XLEN-1:0]  redirect_pc
);

    logic [`EXU_XLEN-1:0]  opnd_a, opnd_b;
    logic [`EXU_XLEN-1:0]  alu_out, target;
    logic                  taken, is_mem, is_jump, accept;
    logic                  res_pending, load_pend, hazard, mem_block;
    logic [`EXU_REG_W-1:0] load_rd;

    // ----------------------------------------
    // operand select and target
    // ----------------------------------------

    assign opnd_a  = op.src_a_pc  ? pc  : rs1;
    assign opnd_b  = op.src_b_imm ? imm : rs2;
    assign is_mem  = (op.mem_kind != exu_pkg::mem_none);
    assign is_jump = (op.branch == exu_pkg::br_jal) || (op.branch == exu_pkg::br_jalr);

    // jalr target has bit 0 cleared
    assign target = (op.branch == exu_pkg::br_jalr) ? ((rs1 + imm) & ~32'd1) : (pc + imm);

    alu u_alu_res (
        .a      (opnd_a),
        .b      (opnd_b),
        .op     (op.alu_op),
        .branch (exu_pkg::br_none),
        .result (alu_out),
        .taken  ()
    );

    // branch compare always on register values
    alu u_alu_cmp (
        .a      (rs1),
        .b      (rs2),
        .op     (exu_pkg::alu_sub),
        .branch (op.branch),
        .result (),
        .taken  (taken)
    );

    // ----------------------------------------
    // issue control
    // ----------------------------------------

    // a pending load blocks its dependents and any further memory op
    assign hazard    = load_pend && (rd == load_rd || rs1_idx == load_rd || rs2_idx == load_rd);
    assign mem_block = is_mem && (load_pend || (mem_valid && !lsu_ready));

    // result held back a cycle when the load write-back wins
    assign issue_ready = !(res_pending && lsu_wb) && !hazard && !mem_block;
    assign accept      = issue_valid && issue_ready;
    assign wb_valid    = res_pending && !lsu_wb;

    always_ff @(posedge clock) begin
        if (reset) begin
            res_pending    <= 1'b0;
            redirect_valid <= 1'b0;
            mem_valid      <= 1'b0;
            load_pend      <= 1'b0;
            load_rd        <= '0;
        end else begin
            if (accept && !is_mem && op.rd_write)
                res_pending <= 1'b1;
            else if (!lsu_wb)
                res_pending <= 1'b0;

            redirect_valid <= accept && taken;

            if (accept && is_mem)
                mem_valid <= 1'b1;
            else if (lsu_ready)
                mem_valid <= 1'b0;

            if (accept && op.mem_kind == exu_pkg::mem_load) begin
                load_pend <= 1'b1;
                load_rd   <= rd;
            end else if (load_done) begin
                load_pend <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // payload registers
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (accept) begin
            wb_rd       <= rd;
            wb_data     <= is_jump ? pc + 32'd4 : alu_out;
            redirect_pc <= target;
        end
        if (accept && is_mem) begin
            mem_req.write     <= (op.mem_kind == exu_pkg::mem_store);
            mem_req.addr      <= rs1 + imm;
            mem_req.wdata     <= rs2;
            mem_req.size      <= op.mem_size;
            mem_req.signed_ld <= op.mem_signed;
            mem_req.rd        <= rd;
            mem_req.pc        <= pc;
        end
    end

endmodule

// File: exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// data and byte-address width
`define EXU_XLEN 32

// register index width
`define EXU_REG_W 5

// ----------------------------------------
// data memory
// ----------------------------------------

`define EXU_MEM_WORDS 1024

// word address width into the sram
`define EXU_MEM_AW $clog2(`EXU_MEM_WORDS)

`endif

// File: exu_pkg.sv
`include "exu_consts.svh"

package exu_pkg;

    // ----------------------------------------
    // operation encodings
    // ----------------------------------------

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt,
        alu_sltu, alu_xor, alu_srl, alu_sra,
        alu_or, alu_and, alu_pass_b
    } alu_op_e;

    // jal/jalr always redirect, the rest compare rs1 against rs2
    typedef enum logic [2:0] {
        br_none, br_jal, br_jalr, br_beq,
        br_bne, br_blt, br_bge, br_bltu
    } branch_e;

    typedef enum logic [1:0] {
        mem_none, mem_load, mem_store
    } mem_kind_e;

    typedef enum logic [1:0] {
        size_byte, size_half, size_word
    } mem_size_e;

    // ----------------------------------------
    // decoded operation
    // ----------------------------------------

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src_a_pc;
        logic      src_b_imm;
        branch_e   branch;
        mem_kind_e mem_kind;
        mem_size_e mem_size;
        logic      mem_signed;
        logic      rd_write;
    } exu_op_t;

    // execute to memory hand-off
    typedef struct packed {
        logic                   write;
        logic [`EXU_XLEN-1:0]   addr;
        logic [`EXU_XLEN-1:0]   wdata;
        mem_size_e              size;
        logic                   signed_ld;
        logic [`EXU_REG_W-1:0]  rd;
        logic [`EXU_XLEN-1:0]   pc;
    } mem_req_t;

endpackage

// File: load_store_unit.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module load_store_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  mem_valid,
    output logic                  lsu_ready,
    input  exu_pkg::mem_req_t     mem_req,
    mem_bus_if.master             bus,
    output logic                  load_done,
    output logic                  lsu_wb,
    output logic [`EXU_REG_W-1:0] wb_rd,
    output logic [`EXU_XLEN-1:0]  wb_data,
    output logic                  store_done
);

    typedef enum logic [1:0] {st_idle, st_request, st_wait} state_e;

    state_e               state;
    exu_pkg::mem_req_t    req_q;
    logic [`EXU_XLEN-1:0] lane;
    logic                 sign;

    // ----------------------------------------
    // request build
    // ----------------------------------------

    assign lsu_ready = (state == st_idle);
    assign bus.req   = (state == st_request);
    assign bus.write = req_q.write;
    assign bus.addr  = req_q.addr[`EXU_MEM_AW+1:2];

    always_comb begin
        case (req_q.size)
            exu_pkg::size_byte: begin
                bus.be    = 4'b0001 << req_q.addr[1:0];
                bus.wdata = {4{req_q.wdata[7:0]}};
            end
            exu_pkg::size_half: begin
                bus.be    = 4'b0011 << {req_q.addr[1], 1'b0};
                bus.wdata = {2{req_q.wdata[15:0]}};
            end
            default: begin
                bus.be    = 4'b1111;
                bus.wdata = req_q.wdata;
            end
        endcase
    end

    // ----------------------------------------
    // load alignment
    // ----------------------------------------

    assign lane = bus.rdata >> {req_q.addr[1:0], 3'b000};

    always_comb begin
        case (req_q.size)
            exu_pkg::size_byte: begin
                sign    = req_q.signed_ld && lane[7];
                wb_data = {{(`EXU_XLEN-8){sign}}, lane[7:0]};
            end
            exu_pkg::size_half: begin
                sign    = req_q.signed_ld && lane[15];
                wb_data = {{(`EXU_XLEN-16){sign}}, lane[15:0]};
            end
            default: begin
                sign    = 1'b0;
                wb_data = lane;
            end
        endcase
    end

    assign wb_rd      = req_q.rd;
    assign lsu_wb     = (state == st_wait) && bus.rvalid;
    assign load_done  = lsu_wb;
    assign store_done = bus.req && bus.gnt && req_q.write;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (mem_valid) state <= st_request;
                st_request: if (bus.gnt) state <= req_q.write ? st_idle : st_wait;
                st_wait:    if (bus.rvalid) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (lsu_ready && mem_valid)
            req_q <= mem_req;
    end

endmodule

// File: mem_bus_if.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

interface mem_bus_if;

    // request side is held until gnt
    logic                     req;
    logic                     write;
    logic [`EXU_MEM_AW-1:0]   addr;
    logic [`EXU_XLEN-1:0]     wdata;
    logic [3:0]               be;

    // rvalid follows a granted read by one cycle
    logic                     gnt;
    logic                     rvalid;
    logic [`EXU_XLEN-1:0]     rdata;

    modport master (
        output req, write, addr, wdata, be,
        input  gnt, rvalid, rdata
    );

    modport slave (
        input  req, write, addr, wdata, be,
        output gnt, rvalid, rdata
    );

    modport monitor (
        input req, write, addr, wdata, be, gnt, rvalid, rdata
    );

endinterface

// File: tb_exec_top.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module tb_exec_top;

    logic                   clock;
    logic                   reset;
    logic                   issue_valid;
    logic                   issue_ready;
    exu_pkg::exu_op_t       op;
    logic [`EXU_REG_W-1:0]  rd, rs1_idx, rs2_idx;
    logic [`EXU_XLEN-1:0]   pc, imm, rs1, rs2;
    logic                   wb_valid;
    logic [`EXU_REG_W-1:0]  wb_rd;
    logic [`EXU_XLEN-1:0]   wb_data;
    logic                   redirect_valid;
    logic [`EXU_XLEN-1:0]   redirect_pc;
    logic                   store_done;
    logic                   host_req, host_write;
    logic [`EXU_MEM_AW-1:0] host_addr;
    logic [`EXU_XLEN-1:0]   host_wdata;
    logic [3:0]             host_be;
    logic                   host_gnt, host_rvalid;
    logic [`EXU_XLEN-1:0]   host_rdata;

    logic [31:0] shadow [`EXU_MEM_WORDS];
    integer      seed = 32'hfa6d;
    int          errors = 0;
    int          cycle = 0;
    int          accept_cycle;

    // write-back and redirect events seen at the falling edge
    logic [4:0]  wb_rd_q [$];
    logic [31:0] wb_data_q [$];
    int          wb_cyc_q [$];
    logic [31:0] rdr_pc_q [$];
    int          rdr_cyc_q [$];

    exec_top uut (.*);

    always #50 clock = ~clock;

    always @(posedge clock) cycle++;

    always @(negedge clock) begin
        if (wb_valid) begin
            wb_rd_q.push_back(wb_rd);
            wb_data_q.push_back(wb_data);
            wb_cyc_q.push_back(cycle);
        end
        if (redirect_valid) begin
            rdr_pc_q.push_back(redirect_pc);
            rdr_cyc_q.push_back(cycle);
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic logic [31:0] expect_alu(exu_pkg::alu_op_e o, logic [31:0] a, b);
        case (o)
            exu_pkg::alu_add:  return a + b;
            exu_pkg::alu_sub:  return a - b;
            exu_pkg::alu_sll:  return a << b[4:0];
            exu_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exu_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            exu_pkg::alu_xor:  return a ^ b;
            exu_pkg::alu_srl:  return a >> b[4:0];
            exu_pkg::alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            exu_pkg::alu_or:   return a | b;
            exu_pkg::alu_and:  return a & b;
            default:           return b;
        endcase
    endfunction

    function automatic logic expect_taken(exu_pkg::branch_e br, logic [31:0] a, b);
        case (br)
            exu_pkg::br_jal, exu_pkg::br_jalr: return 1'b1;
            exu_pkg::br_beq:  return a == b;
            exu_pkg::br_bne:  return a != b;
            exu_pkg::br_blt:  return $signed(a) < $signed(b);
            exu_pkg::br_bge:  return $signed(a) >= $signed(b);
            exu_pkg::br_bltu: return a < b;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] expect_load(logic [31:0] addr, exu_pkg::mem_size_e sz,
                                                logic sgn);
        logic [31:0] lane;
        lane = shadow[addr[11:2]] >> (8 * addr[1:0]);
        case (sz)
            exu_pkg::size_byte: return {{24{sgn & lane[7]}}, lane[7:0]};
            exu_pkg::size_half: return {{16{sgn & lane[15]}}, lane[15:0]};
            default:            return lane;
        endcase
    endfunction

    function automatic exu_pkg::exu_op_t make_op(exu_pkg::alu_op_e a, logic a_pc, b_imm,
            exu_pkg::branch_e br, exu_pkg::mem_kind_e mk, exu_pkg::mem_size_e ms,
            logic sgn, logic rdw);
        exu_pkg::exu_op_t o;
        o.alu_op     = a;
        o.src_a_pc   = a_pc;
        o.src_b_imm  = b_imm;
        o.branch     = br;
        o.mem_kind   = mk;
        o.mem_size   = ms;
        o.mem_signed = sgn;
        o.rd_write   = rdw;
        return o;
    endfunction

    // ----------------------------------------
    // drivers
    // ----------------------------------------

    task automatic issue(exu_pkg::exu_op_t o, logic [4:0] d, s1, s2,
                         logic [31:0] p, im, a, b);
        int t;
        op = o;
        rd = d;
        rs1_idx = s1;
        rs2_idx = s2;
        pc = p;
        imm = im;
        rs1 = a;
        rs2 = b;
        issue_valid = 1'b1;
        t = 0;
        @(negedge clock);
        while (!issue_ready && t < 50) begin
            @(negedge clock);
            t++;
        end
        if (!issue_ready) begin
            $display("issue_ready never rose, operation was not accepted");
            errors++;
        end
        @(posedge clock);
        #2;
        accept_cycle = cycle;
        issue_valid = 1'b0;
    endtask

    task automatic wait_wb(output logic [4:0] r, output logic [31:0] data, output int cyc);
        int t;
        t = 0;
        while (wb_rd_q.size() == 0 && t < 50) begin
            @(posedge clock);
            #2;
            t++;
        end
        if (wb_rd_q.size() == 0) begin
            $display("no write-back arrived before the timeout");
            errors++;
            r = 'x;
            data = 'x;
            cyc = -1;
        end else begin
            r = wb_rd_q.pop_front();
            data = wb_data_q.pop_front();
            cyc = wb_cyc_q.pop_front();
        end
    endtask

    task automatic check_wb(logic [4:0] exp_rd, logic [31:0] exp_data, int exp_cyc);
        logic [4:0]  r;
        logic [31:0] data;
        int          cyc;
        wait_wb(r, data, cyc);
        if (r !== exp_rd || data !== exp_data)
            $display("ERROR at %0t: wb rd %0d data %h, expected rd %0d data %h",
                     $time, r, data, exp_rd, exp_data);
        if (r !== exp_rd || data !== exp_data)
            errors++;
        if (exp_cyc >= 0 && cyc != exp_cyc) begin
            $display("ERROR at %0t: wb in cycle %0d, expected %0d", $time, cyc, exp_cyc);
            errors++;
        end
    endtask

    task automatic lsu_store(logic [31:0] addr, exu_pkg::mem_size_e sz, logic [31:0] data);
        int t;
        issue(make_op(exu_pkg::alu_add, 0, 1, exu_pkg::br_none, exu_pkg::mem_store, sz, 0, 0),
              0, 1, 2, 0, addr & 32'h3, addr & ~32'h3, data);
        t = 0;
        @(negedge clock);
        while (!store_done && t < 50) begin
            @(negedge clock);
            t++;
        end
        if (!store_done) begin
            $display("store_done never pulsed for a store");
            errors++;
        end
        case (sz)
            exu_pkg::size_byte: shadow[addr[11:2]][8*addr[1:0] +: 8] = data[7:0];
            exu_pkg::size_half: shadow[addr[11:2]][8*addr[1:0] +: 16] = data[15:0];
            default:            shadow[addr[11:2]] = data;
        endcase
        @(posedge clock);
        #2;
    endtask

    task automatic lsu_load(logic [31:0] addr, exu_pkg::mem_size_e sz, logic sgn,
                            logic [4:0] d);
        issue(make_op(exu_pkg::alu_add, 0, 1, exu_pkg::br_none, exu_pkg::mem_load, sz, sgn, 1),
              d, 1, 2, 0, addr & 32'h3, addr & ~32'h3, 0);
        check_wb(d, expect_load(addr, sz, sgn), -1);
    endtask

    task automatic host_access(logic wr, logic [9:0] a, logic [31:0] data, logic [3:0] be);
        int t;
        host_req = 1'b1;
        host_write = wr;
        host_addr = a;
        host_wdata = data;
        host_be = be;
        t = 0;
        @(negedge clock);
        while (!host_gnt && t < 50) begin
            @(negedge clock);
            t++;
        end
        if (!host_gnt) begin
            $display("host request was never granted");
            errors++;
        end
        @(posedge clock);
        #2;
        host_req = 1'b0;
        if (wr) begin
            for (int i = 0; i < 4; i++)
                if (be[i])
                    shadow[a][8*i +: 8] = data[8*i +: 8];
        end else begin
            @(negedge clock);
            if (!host_rvalid || host_rdata !== shadow[a]) begin
                $display("ERROR at %0t: host read %h valid %b, expected %h",
                         $time, host_rdata, host_rvalid, shadow[a]);
                errors++;
            end
            @(posedge clock);
            #2;
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic test_reset();
        @(negedge clock);
        if (wb_valid || redirect_valid || store_done || host_gnt || host_rvalid) begin
            $display("ERROR at %0t: outputs not low after reset", $time);
            errors++;
        end
        @(posedge clock);
        #2;
    endtask

    task automatic test_alu();
        logic [31:0] a, b, p, im;
        exu_pkg::alu_op_e o;
        for (int k = 0; k < 11; k++) begin
            for (int sel = 0; sel < 4; sel++) begin
                o = exu_pkg::alu_op_e'(k);
                a = $random(seed);
                b = $random(seed);
                p = $random(seed);
                im = $random(seed);
                issue(make_op(o, sel[0], sel[1], exu_pkg::br_none, exu_pkg::mem_none,
                              exu_pkg::size_word, 0, 1), 5'd3 + k, 1, 2, p, im, a, b);
                check_wb(5'd3 + k, expect_alu(o, sel[0] ? p : a, sel[1] ? im : b),
                         accept_cycle);
            end
        end
    endtask

    task automatic test_branch();
        logic [31:0] a, b, p, im, target;
        logic        tk;
        exu_pkg::branch_e br;
        for (int k = 1; k < 8; k++) begin
            for (int n = 0; n < 4; n++) begin
                br = exu_pkg::branch_e'(k);
                a = $random(seed);
                b = (n == 0) ? a : $random(seed);
                p = $random(seed) & ~32'h3;
                im = $random(seed) & 32'hffe;
                tk = expect_taken(br, a, b);
                target = (br == exu_pkg::br_jalr) ? ((a + im) & ~32'd1) : (p + im);
                issue(make_op(exu_pkg::alu_add, 0, 1, br, exu_pkg::mem_none,
                              exu_pkg::size_word, 0, k < 3), 5'd1, 1, 2, p, im, a, b);
                @(posedge clock);
                #2;
                if (tk) begin
                    if (rdr_pc_q.size() != 1 || rdr_pc_q[0] !== target
                            || rdr_cyc_q[0] != accept_cycle) begin
                        $display("ERROR at %0t: redirect missing or wrong, expected %h",
                                 $time, target);
                        errors++;
                    end
                end else if (rdr_pc_q.size() != 0) begin
                    $display("ERROR at %0t: redirect on a branch not taken", $time);
                    errors++;
                end
                rdr_pc_q.delete();
                rdr_cyc_q.delete();
                if (k < 3)
                    check_wb(5'd1, p + 32'd4, accept_cycle);
                else if (wb_rd_q.size() != 0) begin
                    $display("ERROR at %0t: write-back from a conditional branch", $time);
                    errors++;
                end
            end
        end
    endtask

    task automatic test_mem();
        logic [31:0] addr;
        for (int k = 0; k < 4; k++)
            host_access(1, 10'd64 + k, $random(seed), 4'hf);
        for (int k = 0; k < 4; k++) begin
            for (int off = 0; off < 4; off++) begin
                addr = 32'h100 + 4 * k + off;
                if (k < 2 || (k == 2 && off[0] == 0) || (k == 3 && off == 0)) begin
                    lsu_store(addr, exu_pkg::mem_size_e'(k < 2 ? 0 : k - 1), $random(seed));
                    lsu_load(addr, exu_pkg::mem_size_e'(k < 2 ? 0 : k - 1), 1, 5'd6);
                    lsu_load(addr, exu_pkg::mem_size_e'(k < 2 ? 0 : k - 1), 0, 5'd7);
                end
            end
        end
    endtask

    task automatic test_interlock();
        logic [31:0] a;
        a = $random(seed);
        issue(make_op(exu_pkg::alu_add, 0, 1, exu_pkg::br_none, exu_pkg::mem_load,
                      exu_pkg::size_word, 0, 1), 5'd5, 1, 2, 0, 0, 32'h100, 0);
        issue(make_op(exu_pkg::alu_add, 0, 0, exu_pkg::br_none, exu_pkg::mem_none,
                      exu_pkg::size_word, 0, 1), 5'd7, 1, 2, 0, 0, a, 32'd1);
        issue(make_op(exu_pkg::alu_xor, 0, 0, exu_pkg::br_none, exu_pkg::mem_none,
                      exu_pkg::size_word, 0, 1), 5'd9, 5, 2, 0, 0, a, 32'hff);
        // write-back order must be independent op, load, dependent op
        check_wb(5'd7, a + 32'd1, -1);
        check_wb(5'd5, shadow[64], -1);
        check_wb(5'd9, a ^ 32'hff, -1);
    endtask

    task automatic test_host();
        fork
            lsu_store(32'h320, exu_pkg::size_word, $random(seed));
            host_access(1, 10'd201, $random(seed), 4'hf);
        join
        @(posedge clock);
        #2;
        // host read lands in the same cycle as the lsu read request
        fork
            begin
                repeat (2) @(posedge clock);
                #2;
                host_access(0, 10'd200, 0, 4'h0);
            end
            lsu_load(32'h324, exu_pkg::size_word, 0, 5'd8);
        join
        @(posedge clock);
        #2;
        host_access(1, 10'd200, $random(seed), 4'b0110);
        lsu_load(32'h322, exu_pkg::size_half, 1, 5'd4);
    endtask

    initial begin
        clock = 0;
        reset = 1;
        issue_valid = 0;
        op = '0;
        rd = 0;
        rs1_idx = 0;
        rs2_idx = 0;
        pc = 0;
        imm = 0;
        rs1 = 0;
        rs2 = 0;
        host_req = 0;
        host_write = 0;
        host_addr = 0;
        host_wdata = 0;
        host_be = 0;
        repeat (10) @(posedge clock);
        #2;
        reset = 0;
        test_reset();
        test_alu();
        test_branch();
        test_mem();
        test_interlock();
        test_host();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
